//--- source/tx_gen_defines.svh
////////////////////
// widths, counts and fixed words of the
// test traffic generator
////////////////////

`ifndef TX_GEN_DEFINES_SVH
`define TX_GEN_DEFINES_SVH

`define TXG_WORD_W       32            // frame data word
`define TXG_STREAMS      8             // test streams
`define TXG_STREAM_W     3
`define TXG_HDR_WORDS    3             // header words per frame
`define TXG_TAG_WORDS    3             // seq, time, stream/signature
`define TXG_PLEN_W       9             // payload length in words
`define TXG_FLEN_W       16            // frame length in bytes
`define TXG_FIFO_DEPTH   8

// "T" "R" "I" under the stream index
`define TXG_TAG_SIG      24'h54_52_49

`define TXG_RUNT_BYTES   64
`define TXG_JUMBO_BYTES  1518
`define TXG_CRC_INIT     32'hFFFF_FFFF

`endif

//--- source/tx_gen_pkg.sv
////////////////////
// shared types of the generator
// word, stream and length vectors, sequencer states
////////////////////

`default_nettype none

`include "tx_gen_defines.svh"

package tx_gen_pkg;

    typedef logic [`TXG_WORD_W-1:0]   word_t;
    typedef logic [`TXG_STREAM_W-1:0] stream_t;
    typedef logic [`TXG_PLEN_W-1:0]   plen_t;
    typedef logic [`TXG_FLEN_W-1:0]   flen_t;

    // {stream, word}; word 0 is payload control, 1..3 header
    typedef logic [`TXG_STREAM_W+1:0] cfg_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD,
        TAG
    } seq_state_t;

endpackage

`default_nettype wire

//--- source/frame_sequencer.sv
////////////////////
// frame producer: config memory, per-stream
// sequence and payload counters, frame FSM
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tx_gen_defines.svh"

module frame_sequencer
    import tx_gen_pkg::*;
(
    input  wire            rst,          // clock
    input  wire            clk,          // async reset, active high
    input  wire            req_valid_i,
    input  wire stream_t   req_stream_i,
    input  wire plen_t     req_plen_i,
    output logic           req_ready_o,
    input  wire            cfg_we_i,
    input  wire cfg_addr_t cfg_addr_i,
    input  wire word_t     cfg_wdata_i,
    input  wire word_t     time_i,
    output logic           sq_valid_o,
    output word_t          sq_data_o,
    output logic           sq_last_o,
    output stream_t        sq_stream_o,
    input  wire            sq_ready_i
);

    localparam int    CFG_WORDS = `TXG_STREAMS * 4;
    localparam plen_t HDR_LAST  = plen_t'(`TXG_HDR_WORDS - 1);
    localparam plen_t TAG_LAST  = plen_t'(`TXG_TAG_WORDS - 1);

    word_t      cfg_mem [CFG_WORDS];
    word_t      seq_num [`TXG_STREAMS];
    word_t      pay_cnt [`TXG_STREAMS];

    seq_state_t state;
    plen_t      word_cnt;     // position inside the current section
    stream_t    cur_stream;
    plen_t      cur_plen;
    word_t      ts_q;

    logic       req_xfer;
    logic       sq_xfer;
    logic       incr_mode;
    logic [1:0] hdr_idx;
    word_t      ctrl_word;
    word_t      hdr_word;
    word_t      pay_word;
    word_t      tag_word;

    assign req_ready_o = (state == IDLE);
    assign req_xfer    = req_valid_i && req_ready_o;
    assign sq_xfer     = sq_valid_o && sq_ready_i;

    // configuration writes
    always_ff @(posedge rst) begin
        if (cfg_we_i)
            cfg_mem[cfg_addr_i] <= cfg_wdata_i;
    end

    ////////////////////
    // word select
    ////////////////////

    assign ctrl_word = cfg_mem[{cur_stream, 2'd0}];
    assign incr_mode = ctrl_word[16];
    assign hdr_idx   = word_cnt[1:0] + 2'd1;        // header sits at words 1..3
    assign hdr_word  = cfg_mem[{cur_stream, hdr_idx}];
    assign pay_word  = incr_mode ? pay_cnt[cur_stream] : {4{ctrl_word[7:0]}};

    always_comb begin
        case (word_cnt[1:0])
            2'd0:    tag_word = seq_num[cur_stream];
            2'd1:    tag_word = ts_q;
            default: tag_word = word_t'({cur_stream, `TXG_TAG_SIG});
        endcase
    end

    always_comb begin
        case (state)
            HEADER:  sq_data_o = hdr_word;
            PAYLOAD: sq_data_o = pay_word;
            default: sq_data_o = tag_word;
        endcase
    end

    assign sq_valid_o  = (state != IDLE);
    assign sq_last_o   = (state == TAG) && (word_cnt == TAG_LAST);
    assign sq_stream_o = cur_stream;

    ////////////////////
    // frame FSM
    ////////////////////

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state      <= IDLE;
            word_cnt   <= '0;
            cur_stream <= '0;
            cur_plen   <= '0;
        end else begin
            case (state)
                IDLE: if (req_xfer) begin
                    state      <= HEADER;
                    word_cnt   <= '0;
                    cur_stream <= req_stream_i;
                    cur_plen   <= req_plen_i;
                end
                HEADER: if (sq_xfer) begin
                    if (word_cnt == HDR_LAST) begin
                        word_cnt <= '0;
                        state    <= (cur_plen == '0) ? TAG : PAYLOAD;   // empty payload skips ahead
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                PAYLOAD: if (sq_xfer) begin
                    if (word_cnt == cur_plen - 1'b1) begin
                        word_cnt <= '0;
                        state    <= TAG;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: if (sq_xfer) begin
                    if (word_cnt == TAG_LAST) begin
                        word_cnt <= '0;
                        state    <= IDLE;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // per-stream counters
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < `TXG_STREAMS; i++) begin
                seq_num[i] <= '0;
                pay_cnt[i] <= '0;
            end
        end else if (sq_xfer) begin
            if (state == PAYLOAD && incr_mode)
                pay_cnt[cur_stream] <= pay_cnt[cur_stream] + 1'b1;   // carries into next frame
            if (sq_last_o)
                seq_num[cur_stream] <= seq_num[cur_stream] + 1'b1;
        end
    end

    // time stamp taken as the first tag word goes out
    always_ff @(posedge rst) begin
        if (sq_xfer && state == TAG && word_cnt == '0)
            ts_q <= time_i;
    end

endmodule

`default_nettype wire

//--- source/word_fifo.sv
////////////////////
// frame word FIFO with valid/ready on both sides
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tx_gen_defines.svh"

module word_fifo
    import tx_gen_pkg::*;
#(
    parameter int DEPTH = `TXG_FIFO_DEPTH
) (
    input  wire          rst,
    input  wire          clk,
    input  wire          push_valid_i,
    input  wire word_t   push_data_i,
    input  wire          push_last_i,
    input  wire stream_t push_stream_i,
    output logic         push_ready_o,
    output logic         pop_valid_o,
    output word_t        pop_data_o,
    output logic         pop_last_o,
    output stream_t      pop_stream_o,
    input  wire          pop_ready_i
);

    localparam int              AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW:0]     FULL_CNT = (AW+1)'(DEPTH);
    localparam logic [AW-1:0]   LAST_PTR = AW'(DEPTH - 1);

    word_t         data_mem   [DEPTH];
    logic          last_mem   [DEPTH];
    stream_t       stream_mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == LAST_PTR) ? '0 : p + 1'b1;
    endfunction

    assign push_ready_o = (count != FULL_CNT);
    assign pop_valid_o  = (count != '0);
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    assign pop_data_o   = data_mem[rd_ptr];
    assign pop_last_o   = last_mem[rd_ptr];
    assign pop_stream_o = stream_mem[rd_ptr];

    always_ff @(posedge rst) begin
        if (push) begin
            data_mem[wr_ptr]   <= push_data_i;
            last_mem[wr_ptr]   <= push_last_i;
            stream_mem[wr_ptr] <= push_stream_i;
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/crc_appender.sv
////////////////////
// frame consumer: CRC-32 append, sop/eop marking,
// per-frame length statistics
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tx_gen_defines.svh"

module crc_appender
    import tx_gen_pkg::*;
(
    input  wire          rst,
    input  wire          clk,
    input  wire          in_valid_i,
    input  wire word_t   in_data_i,
    input  wire          in_last_i,
    input  wire stream_t in_stream_i,
    output logic         in_ready_o,
    output logic         out_valid_o,
    output word_t        out_data_o,
    output logic         out_sop_o,
    output logic         out_eop_o,
    input  wire          out_ready_i,
    output logic         stat_valid_o,
    output stream_t      stat_stream_o,
    output flen_t        stat_len_o,
    output logic         stat_runt_o,
    output logic         stat_jumbo_o
);

    localparam word_t CRC_POLY   = 32'hEDB8_8320;     // reflected 802.3 polynomial
    localparam flen_t WORD_BYTES = flen_t'(`TXG_WORD_W / 8);
    localparam flen_t RUNT_LEN   = flen_t'(`TXG_RUNT_BYTES);
    localparam flen_t JUMBO_LEN  = flen_t'(`TXG_JUMBO_BYTES);

    logic    out_free;
    logic    in_xfer;
    logic    out_xfer;
    logic    sop_pend;       // next accepted word opens a frame
    logic    crc_pend;
    word_t   crc_q;
    word_t   crc_base;
    word_t   fcs;
    flen_t   len_q;
    flen_t   frame_len;
    stream_t frame_stream_q;

    // byte-wise update, most significant byte first
    function automatic word_t crc32_word(input word_t crc_in, input word_t data);
        word_t c;
        c = crc_in;
        for (int b = 3; b >= 0; b--) begin
            c = c ^ word_t'(data[b*8 +: 8]);
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
            end
        end
        return c;
    endfunction

    assign out_free   = !out_valid_o || out_ready_i;
    assign in_ready_o = out_free && !crc_pend;
    assign in_xfer    = in_valid_i && in_ready_o;
    assign out_xfer   = out_valid_o && out_ready_i;
    assign crc_base   = sop_pend ? `TXG_CRC_INIT : crc_q;
    assign fcs        = ~crc_q;
    assign frame_len  = len_q + WORD_BYTES;            // data bytes plus FCS

    ////////////////////
    // output control
    ////////////////////

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            out_valid_o  <= 1'b0;
            out_sop_o    <= 1'b0;
            out_eop_o    <= 1'b0;
            sop_pend     <= 1'b1;
            crc_pend     <= 1'b0;
            stat_valid_o <= 1'b0;
        end else begin
            stat_valid_o <= out_xfer && out_eop_o;
            if (in_xfer) begin
                out_valid_o <= 1'b1;
                out_sop_o   <= sop_pend;
                out_eop_o   <= 1'b0;
                sop_pend    <= in_last_i;
                crc_pend    <= in_last_i;
            end else if (crc_pend && out_free) begin
                out_valid_o <= 1'b1;                   // CRC word closes the frame
                out_sop_o   <= 1'b0;
                out_eop_o   <= 1'b1;
                crc_pend    <= 1'b0;
            end else if (out_xfer) begin
                out_valid_o <= 1'b0;
                out_sop_o   <= 1'b0;
                out_eop_o   <= 1'b0;
            end
        end
    end

    // data path, CRC and length
    always_ff @(posedge rst) begin
        if (in_xfer) begin
            out_data_o     <= in_data_i;
            crc_q          <= crc32_word(crc_base, in_data_i);
            len_q          <= sop_pend ? WORD_BYTES : len_q + WORD_BYTES;
            frame_stream_q <= in_stream_i;
        end else if (crc_pend && out_free) begin
            // first FCS byte on the wire goes in the top lane
            out_data_o <= {fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};
        end
        if (out_xfer && out_eop_o) begin
            stat_stream_o <= frame_stream_q;
            stat_len_o    <= frame_len;
            stat_runt_o   <= (frame_len < RUNT_LEN);
            stat_jumbo_o  <= (frame_len > JUMBO_LEN);
        end
    end

endmodule

`default_nettype wire

//--- source/tx_gen_top.sv
////////////////////
// generator top: sequencer, FIFO, CRC appender
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tx_gen_defines.svh"

module tx_gen_top
    import tx_gen_pkg::*;
(
    input  wire            rst,
    input  wire            clk,
    input  wire            req_valid_i,
    input  wire stream_t   req_stream_i,
    input  wire plen_t     req_plen_i,
    output logic           req_ready_o,
    input  wire            cfg_we_i,
    input  wire cfg_addr_t cfg_addr_i,
    input  wire word_t     cfg_wdata_i,
    input  wire word_t     time_i,
    output logic           out_valid_o,
    output word_t          out_data_o,
    output logic           out_sop_o,
    output logic           out_eop_o,
    input  wire            out_ready_i,
    output logic           stat_valid_o,
    output stream_t        stat_stream_o,
    output flen_t          stat_len_o,
    output logic           stat_runt_o,
    output logic           stat_jumbo_o
);

    logic    sq_valid;
    logic    sq_ready;
    word_t   sq_data;
    logic    sq_last;
    stream_t sq_stream;

    logic    fb_valid;
    logic    fb_ready;
    word_t   fb_data;
    logic    fb_last;
    stream_t fb_stream;

    frame_sequencer u_seq (
        .rst          (rst),
        .clk          (clk),
        .req_valid_i  (req_valid_i),
        .req_stream_i (req_stream_i),
        .req_plen_i   (req_plen_i),
        .req_ready_o  (req_ready_o),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .time_i       (time_i),
        .sq_valid_o   (sq_valid),
        .sq_data_o    (sq_data),
        .sq_last_o    (sq_last),
        .sq_stream_o  (sq_stream),
        .sq_ready_i   (sq_ready)
    );

    // decouples the next frame from output stalls
    word_fifo #(
        .DEPTH (`TXG_FIFO_DEPTH)
    ) u_fifo (
        .rst           (rst),
        .clk           (clk),
        .push_valid_i  (sq_valid),
        .push_data_i   (sq_data),
        .push_last_i   (sq_last),
        .push_stream_i (sq_stream),
        .push_ready_o  (sq_ready),
        .pop_valid_o   (fb_valid),
        .pop_data_o    (fb_data),
        .pop_last_o    (fb_last),
        .pop_stream_o  (fb_stream),
        .pop_ready_i   (fb_ready)
    );

    crc_appender u_crc (
        .rst           (rst),
        .clk           (clk),
        .in_valid_i    (fb_valid),
        .in_data_i     (fb_data),
        .in_last_i     (fb_last),
        .in_stream_i   (fb_stream),
        .in_ready_o    (fb_ready),
        .out_valid_o   (out_valid_o),
        .out_data_o    (out_data_o),
        .out_sop_o     (out_sop_o),
        .out_eop_o     (out_eop_o),
        .out_ready_i   (out_ready_i),
        .stat_valid_o  (stat_valid_o),
        .stat_stream_o (stat_stream_o),
        .stat_len_o    (stat_len_o),
        .stat_runt_o   (stat_runt_o),
        .stat_jumbo_o  (stat_jumbo_o)
    );

endmodule

`default_nettype wire

//--- sim/frame_checker.sv
////////////////////
// output checker: reference frame model,
// word, CRC and statistics compare, per-frame report
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tx_gen_defines.svh"

module frame_checker
    import tx_gen_pkg::*;
(
    input  wire            rst,          // clock
    input  wire            clk,          // reset, active high
    input  wire            req_valid_i,
    input  wire            req_ready_i,
    input  wire stream_t   req_stream_i,
    input  wire plen_t     req_plen_i,
    input  wire            cfg_we_i,
    input  wire cfg_addr_t cfg_addr_i,
    input  wire word_t     cfg_wdata_i,
    input  wire word_t     time_i,
    input  wire            out_valid_i,
    input  wire            out_ready_i,
    input  wire word_t     out_data_i,
    input  wire            out_sop_i,
    input  wire            out_eop_i,
    input  wire            stat_valid_i,
    input  wire stream_t   stat_stream_i,
    input  wire flen_t     stat_len_i,
    input  wire            stat_runt_i,
    input  wire            stat_jumbo_i,
    output int             tests_o,      // frames finished
    output int             errors_o
);

    localparam int K_DATA      = 0;      // exact word
    localparam int K_STAMP     = 1;      // time stamp, range only
    localparam int K_CRC       = 2;
    localparam int FIXED_WORDS = `TXG_HDR_WORDS + `TXG_TAG_WORDS + 1;

    word_t   shadow_cfg [`TXG_STREAMS*4];
    word_t   ref_seq    [`TXG_STREAMS];
    word_t   ref_cnt    [`TXG_STREAMS];

    // expected output words, oldest first
    word_t   exp_data_q  [$];
    int      exp_kind_q  [$];
    int      exp_pos_q   [$];
    int      exp_frame_q [$];
    int      build_pos;

    // one record per request, in request order
    stream_t frame_stream_q [$];
    plen_t   frame_plen_q   [$];
    word_t   frame_t0_q     [$];
    int      frame_err_q    [$];

    int      req_cnt;
    int      eop_cnt;
    word_t   crc_run;

    ////////////////////
    // reference model
    ////////////////////

    // 802.3 CRC, one octet, lsb of the octet first
    function automatic word_t crc_byte_step(input word_t crc, input logic [7:0] octet);
        word_t r;
        logic  fb;
        r = crc;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ octet[i];
            r  = r >> 1;
            if (fb)
                r = r ^ 32'hEDB8_8320;
        end
        return r;
    endfunction

    function automatic word_t crc_add_word(input word_t crc, input word_t w);
        word_t r;
        r = crc_byte_step(crc, w[31:24]);   // top byte goes out first
        r = crc_byte_step(r, w[23:16]);
        r = crc_byte_step(r, w[15:8]);
        return crc_byte_step(r, w[7:0]);
    endfunction

    // inverted CRC, first FCS octet in the top lane
    function automatic word_t fcs_word(input word_t crc);
        word_t f;
        f = ~crc;
        return {f[7:0], f[15:8], f[23:16], f[31:24]};
    endfunction

    function automatic void push_word(input word_t data, input int kind, input int f);
        exp_data_q.push_back(data);
        exp_kind_q.push_back(kind);
        exp_pos_q.push_back(build_pos);
        exp_frame_q.push_back(f);
        build_pos++;
    endfunction

    function automatic void build_frame(input int f, input stream_t s, input plen_t n);
        word_t ctrl;
        ctrl      = shadow_cfg[{s, 2'd0}];
        build_pos = 0;
        for (int h = 1; h <= `TXG_HDR_WORDS; h++)
            push_word(shadow_cfg[{s, 2'(h)}], K_DATA, f);
        for (int i = 0; i < int'(n); i++) begin
            if (ctrl[16]) begin
                push_word(ref_cnt[s], K_DATA, f);
                ref_cnt[s] = ref_cnt[s] + 32'd1;    // carries into the next frame
            end else begin
                push_word({4{ctrl[7:0]}}, K_DATA, f);
            end
        end
        push_word(ref_seq[s], K_DATA, f);
        ref_seq[s] = ref_seq[s] + 32'd1;
        push_word('0, K_STAMP, f);
        push_word({5'd0, s, `TXG_TAG_SIG}, K_DATA, f);
        push_word('0, K_CRC, f);
    endfunction

    ////////////////////
    // compares
    ////////////////////

    task automatic compare_value(input string name, input word_t exp, input word_t act,
                                 input int f);
        if (act !== exp) begin
            $display("Error %s: expected 0x%h, actual 0x%h", name, exp, act);
            errors_o++;
            frame_err_q[f] = frame_err_q[f] + 1;
        end
    endtask

    task automatic check_word();
        word_t exp;
        int    kind;
        int    pos;
        int    f;
        string name;
        if (exp_data_q.size() == 0) begin
            $display("output word 0x%h arrived with no frame requested", out_data_i);
            errors_o++;
            return;
        end
        exp  = exp_data_q.pop_front();
        kind = exp_kind_q.pop_front();
        pos  = exp_pos_q.pop_front();
        f    = exp_frame_q.pop_front();
        name = $sformatf("frame %0d word %0d", f, pos);
        if (pos == 0)
            crc_run = `TXG_CRC_INIT;
        case (kind)
            K_STAMP: begin
                // sampled after the request, before this word left
                if (out_data_i < frame_t0_q[f] || out_data_i > time_i) begin
                    $display("Error %s time stamp: expected 0x%h..0x%h, actual 0x%h",
                             name, frame_t0_q[f], time_i, out_data_i);
                    errors_o++;
                    frame_err_q[f] = frame_err_q[f] + 1;
                end
            end
            K_CRC:   compare_value({name, " crc"}, fcs_word(crc_run), out_data_i, f);
            default: compare_value(name, exp, out_data_i, f);
        endcase
        if (kind != K_CRC)
            crc_run = crc_add_word(crc_run, out_data_i);
        compare_value({name, " sop"}, word_t'(pos == 0), word_t'(out_sop_i), f);
        compare_value({name, " eop"}, word_t'(kind == K_CRC), word_t'(out_eop_i), f);
        if (kind == K_CRC)
            eop_cnt++;
    endtask

    task automatic check_stats();
        int    f;
        int    bytes;
        string name;
        f = tests_o;
        if (f >= eop_cnt) begin
            $display("statistics pulse arrived with no finished frame to match");
            errors_o++;
            return;
        end
        bytes = (`TXG_WORD_W / 8) * (int'(frame_plen_q[f]) + FIXED_WORDS);
        name  = $sformatf("frame %0d stat", f);
        compare_value({name, " stream"}, word_t'(frame_stream_q[f]),
                      word_t'(stat_stream_i), f);
        compare_value({name, " length"}, word_t'(bytes), word_t'(stat_len_i), f);
        compare_value({name, " runt"}, word_t'(bytes < `TXG_RUNT_BYTES),
                      word_t'(stat_runt_i), f);
        compare_value({name, " jumbo"}, word_t'(bytes > `TXG_JUMBO_BYTES),
                      word_t'(stat_jumbo_i), f);
        $display("frame %0d stream %0d plen %0d len %0d: %s", f, frame_stream_q[f],
                 frame_plen_q[f], bytes, (frame_err_q[f] == 0) ? "ok" : "mismatch");
        tests_o++;
    endtask

    ////////////////////
    // snoop
    ////////////////////

    always @(posedge rst) begin
        if (clk) begin
            tests_o  = 0;
            errors_o = 0;
            req_cnt  = 0;
            eop_cnt  = 0;
            crc_run  = `TXG_CRC_INIT;
            foreach (ref_seq[i]) begin
                ref_seq[i] = '0;
                ref_cnt[i] = '0;
            end
        end else begin
            if (cfg_we_i)
                shadow_cfg[cfg_addr_i] = cfg_wdata_i;
            if (req_valid_i && req_ready_i) begin
                frame_stream_q.push_back(req_stream_i);
                frame_plen_q.push_back(req_plen_i);
                frame_t0_q.push_back(time_i);
                frame_err_q.push_back(0);
                build_frame(req_cnt, req_stream_i, req_plen_i);
                req_cnt++;
            end
            if (stat_valid_i)
                check_stats();      // next frame may open in this same cycle
            if (out_valid_i && out_ready_i)
                check_word();
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_tx_gen.sv
////////////////////
// testbench top with clock, reset, config load,
// random requests and output stalls, watchdog
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tx_gen_defines.svh"

module tb_tx_gen
    import tx_gen_pkg::*;
();

    localparam int          NUM_FRAMES = 40;
    localparam int unsigned SEED       = 32'had75_3759;
    localparam int          FIXED_WORDS = `TXG_HDR_WORDS + `TXG_TAG_WORDS + 1;

    logic      rst = 1'b0;     // clock
    logic      clk;            // reset, active high
    logic      req_valid;
    stream_t   req_stream;
    plen_t     req_plen;
    logic      req_ready;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    word_t     cfg_wdata;
    word_t     time_cnt;
    logic      out_valid;
    word_t     out_data;
    logic      out_sop;
    logic      out_eop;
    logic      out_ready;
    logic      stat_valid;
    stream_t   stat_stream;
    flen_t     stat_len;
    logic      stat_runt;
    logic      stat_jumbo;
    int        chk_tests;
    int        chk_errors;

    stream_t   list_stream [$];
    plen_t     list_plen   [$];
    int        limit_cycles;

    tx_gen_top UUT (
        .rst           (rst),
        .clk           (clk),
        .req_valid_i   (req_valid),
        .req_stream_i  (req_stream),
        .req_plen_i    (req_plen),
        .req_ready_o   (req_ready),
        .cfg_we_i      (cfg_we),
        .cfg_addr_i    (cfg_addr),
        .cfg_wdata_i   (cfg_wdata),
        .time_i        (time_cnt),
        .out_valid_o   (out_valid),
        .out_data_o    (out_data),
        .out_sop_o     (out_sop),
        .out_eop_o     (out_eop),
        .out_ready_i   (out_ready),
        .stat_valid_o  (stat_valid),
        .stat_stream_o (stat_stream),
        .stat_len_o    (stat_len),
        .stat_runt_o   (stat_runt),
        .stat_jumbo_o  (stat_jumbo)
    );

    frame_checker u_check (
        .rst           (rst),
        .clk           (clk),
        .req_valid_i   (req_valid),
        .req_ready_i   (req_ready),
        .req_stream_i  (req_stream),
        .req_plen_i    (req_plen),
        .cfg_we_i      (cfg_we),
        .cfg_addr_i    (cfg_addr),
        .cfg_wdata_i   (cfg_wdata),
        .time_i        (time_cnt),
        .out_valid_i   (out_valid),
        .out_ready_i   (out_ready),
        .out_data_i    (out_data),
        .out_sop_i     (out_sop),
        .out_eop_i     (out_eop),
        .stat_valid_i  (stat_valid),
        .stat_stream_i (stat_stream),
        .stat_len_i    (stat_len),
        .stat_runt_i   (stat_runt),
        .stat_jumbo_i  (stat_jumbo),
        .tests_o       (chk_tests),
        .errors_o      (chk_errors)
    );

    initial begin
        forever #50 rst = ~rst;     // 100 ns period
    end

    // free-running time stamp source
    initial begin
        forever begin
            @(negedge rst);
            time_cnt = time_cnt + 32'd1;
        end
    end

    ////////////////////
    // stimulus tasks
    ////////////////////

    task automatic write_cfg(input cfg_addr_t addr, input word_t data);
        @(negedge rst);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
    endtask

    task automatic load_config();
        word_t ctrl;
        for (int s = 0; s < `TXG_STREAMS; s++) begin
            ctrl = {15'd0, ~s[0], 8'd0, 8'($urandom)};  // even streams count up
            write_cfg(cfg_addr_t'(s * 4), ctrl);
            for (int w = 1; w < 4; w++)
                write_cfg(cfg_addr_t'(s * 4 + w), $urandom);
        end
        @(negedge rst);
        cfg_we = 1'b0;
    endtask

    // entered on a falling edge and left on the one after the transfer
    task automatic send_request(input stream_t s, input plen_t n);
        req_valid  = 1'b1;
        req_stream = s;
        req_plen   = n;
        while (!req_ready)
            @(negedge rst);
        @(negedge rst);
        req_valid = 1'b0;
    endtask

    task automatic drive_stalls();
        forever begin
            @(negedge rst);
            out_ready = ($urandom % 4) != 0;
        end
    endtask

    task automatic build_list();
        // runt, exactly 64 bytes, jumbo, then a second counting frame
        list_stream.push_back(3'd1);
        list_plen.push_back(9'd0);
        list_stream.push_back(3'd2);
        list_plen.push_back(9'd9);
        list_stream.push_back(3'd3);
        list_plen.push_back(9'd380);
        list_stream.push_back(3'd2);
        list_plen.push_back(9'd5);
        while (list_stream.size() < NUM_FRAMES) begin
            list_stream.push_back(stream_t'($urandom % `TXG_STREAMS));
            list_plen.push_back(plen_t'($urandom % 24));
        end
        limit_cycles = 1000;
        for (int i = 0; i < NUM_FRAMES; i++)
            limit_cycles += 4 * (int'(list_plen[i]) + FIXED_WORDS);
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge rst);
        $display("timeout after %0d cycles with %0d of %0d frames finished",
                 cycles, chk_tests, NUM_FRAMES);
        $display("*** FAILED ***");
        $finish;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        clk        = 1'b1;
        req_valid  = 1'b0;
        req_stream = '0;
        req_plen   = '0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        time_cnt   = '0;
        out_ready  = 1'b0;
        void'($urandom(SEED));
        build_list();
        fork
            drive_stalls();
            watchdog(limit_cycles);
        join_none
        repeat (10) @(negedge rst);
        clk = 1'b0;
        load_config();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_request(list_stream[i], list_plen[i]);
            repeat ($urandom % 3) @(negedge rst);
        end
        while (chk_tests < NUM_FRAMES)
            @(negedge rst);
        repeat (20) @(negedge rst);             // room for stray words or pulses
        $display("%0d of %0d frames checked, %0d errors", chk_tests, NUM_FRAMES, chk_errors);
        if (chk_errors == 0 && chk_tests == NUM_FRAMES)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tx_gen.f
+incdir+source
source/tx_gen_pkg.sv
source/frame_sequencer.sv
source/word_fifo.sv
source/crc_appender.sv
source/tx_gen_top.sv
sim/frame_checker.sv
sim/tb_tx_gen.sv

//--- run.sh
#!/bin/sh
# build the tx_gen testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_tx_gen -f tx_gen.f
./obj_dir/Vtb_tx_gen | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failure"
